//--- csr_pkg.sv
package csr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and base types
    ////////////////////////////////////////////////////////////////////////////
    localparam int xlen = 32;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [xlen-1:0] word_t;

    ////////////////////////////////////////////////////////////////////////////
    // csr addresses
    ////////////////////////////////////////////////////////////////////////////
    // user-level counters, read-only from every mode
    localparam csr_addr_t csr_addr_cycle         = 12'hc00;
    localparam csr_addr_t csr_addr_time          = 12'hc01;
    localparam csr_addr_t csr_addr_instret       = 12'hc02;
    localparam csr_addr_t csr_addr_cycleh        = 12'hc80;
    localparam csr_addr_t csr_addr_timeh         = 12'hc81;
    localparam csr_addr_t csr_addr_instreth      = 12'hc82;

    // machine info, read-only
    localparam csr_addr_t csr_addr_mvendorid     = 12'hf11;
    localparam csr_addr_t csr_addr_marchid       = 12'hf12;
    localparam csr_addr_t csr_addr_mimpid        = 12'hf13;
    localparam csr_addr_t csr_addr_mhartid       = 12'hf14;
    localparam csr_addr_t csr_addr_mconfigptr    = 12'hf15;

    // machine trap setup / counters / scratch
    localparam csr_addr_t csr_addr_mstatus       = 12'h300;
    localparam csr_addr_t csr_addr_misa          = 12'h301;
    localparam csr_addr_t csr_addr_mstatush      = 12'h310;
    localparam csr_addr_t csr_addr_mcountinhibit = 12'h320;
    localparam csr_addr_t csr_addr_mscratch      = 12'h340;
    localparam csr_addr_t csr_addr_mcycle        = 12'hb00;
    localparam csr_addr_t csr_addr_minstret      = 12'hb02;
    localparam csr_addr_t csr_addr_mcycleh       = 12'hb80;
    localparam csr_addr_t csr_addr_minstreth     = 12'hb82;

    ////////////////////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_mode_e;

    // writable targets only
    typedef enum logic [3:0] {
        sel_none,
        sel_mstatus,
        sel_mstatush,
        sel_mcycle_lo,
        sel_mcycle_hi,
        sel_minstret_lo,
        sel_minstret_hi,
        sel_mcountinhibit,
        sel_mscratch
    } csr_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      rd_en;
        logic      wr_en;
        csr_addr_t addr;
        word_t     wr_data;
    } csr_req_t;                          // 46 bits

    typedef struct packed {
        csr_sel_e sel;
        word_t    data;
    } csr_wr_t;                           // 36 bits

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
        logic        cy_inhibit;
        logic        ir_inhibit;
    } counter_vals_t;

    // low half of mstatus, unlisted bits are hardwired
    typedef struct packed {
        logic [18:0] reserved_31_13;
        priv_mode_e  mpp;                 // 12:11
        logic [2:0]  reserved_10_8;
        logic        mpie;                // 7
        logic        reserved_6;
        logic        spie;                // 5, reads as 1
        logic        reserved_4;
        logic        mie;                 // 3
        logic        reserved_2;
        logic        sie;                 // 1, reads as 1
        logic        reserved_0;
    } mstatus_t;

endpackage

//--- csr_decode.sv
module csr_decode #(
    parameter csr_pkg::word_t hart_id = '0,
    parameter csr_pkg::word_t impid   = 32'h1
) (
    input  csr_pkg::csr_req_t      req,
    input  logic                   stall,
    input  csr_pkg::priv_mode_e    priv,
    input  csr_pkg::mstatus_t      status,
    input  csr_pkg::word_t         mscratch,
    input  csr_pkg::counter_vals_t counters,
    input  logic [63:0]            time_val,
    output csr_pkg::word_t         rd_data,
    output logic                   illegal_csr,
    output csr_pkg::csr_wr_t       wr
);

    // rv32, I only
    localparam csr_pkg::word_t misa_val = {2'b01, 4'h0, 17'h0, 1'b1, 8'h0};

    logic              user_hit;
    csr_pkg::word_t    user_data;
    logic              mach_hit;
    csr_pkg::word_t    mach_data;
    csr_pkg::csr_sel_e mach_sel;
    logic              mach_ok;       // machine csr hit with enough privilege
    logic              legal;
    csr_pkg::word_t    inhibit_word;

    assign inhibit_word = {{(csr_pkg::xlen-3){1'b0}},
                           counters.ir_inhibit, 1'b0, counters.cy_inhibit};

    ////////////////////////////////////////////////////////////////////////////
    // user level, open to every mode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        user_hit  = 1'b1;
        user_data = '0;
        case (req.addr)
            csr_pkg::csr_addr_cycle:    user_data = counters.mcycle[31:0];
            csr_pkg::csr_addr_cycleh:   user_data = counters.mcycle[63:32];
            csr_pkg::csr_addr_instret:  user_data = counters.minstret[31:0];
            csr_pkg::csr_addr_instreth: user_data = counters.minstret[63:32];
            csr_pkg::csr_addr_time:     user_data = time_val[31:0];
            csr_pkg::csr_addr_timeh:    user_data = time_val[63:32];
            default:                    user_hit  = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // machine level
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mach_hit  = 1'b1;
        mach_data = '0;
        mach_sel  = csr_pkg::sel_none;   // read-only unless listed below
        case (req.addr)
            csr_pkg::csr_addr_misa:       mach_data = misa_val;
            csr_pkg::csr_addr_mvendorid:  mach_data = '0;
            csr_pkg::csr_addr_marchid:    mach_data = '0;
            csr_pkg::csr_addr_mimpid:     mach_data = impid;
            csr_pkg::csr_addr_mhartid:    mach_data = hart_id;
            csr_pkg::csr_addr_mconfigptr: mach_data = '0;
            csr_pkg::csr_addr_mstatus: begin
                mach_data = status;
                mach_sel  = csr_pkg::sel_mstatus;
            end
            csr_pkg::csr_addr_mstatush: begin
                mach_data = '0;          // no upper bits implemented
                mach_sel  = csr_pkg::sel_mstatush;
            end
            csr_pkg::csr_addr_mcycle: begin
                mach_data = counters.mcycle[31:0];
                mach_sel  = csr_pkg::sel_mcycle_lo;
            end
            csr_pkg::csr_addr_mcycleh: begin
                mach_data = counters.mcycle[63:32];
                mach_sel  = csr_pkg::sel_mcycle_hi;
            end
            csr_pkg::csr_addr_minstret: begin
                mach_data = counters.minstret[31:0];
                mach_sel  = csr_pkg::sel_minstret_lo;
            end
            csr_pkg::csr_addr_minstreth: begin
                mach_data = counters.minstret[63:32];
                mach_sel  = csr_pkg::sel_minstret_hi;
            end
            csr_pkg::csr_addr_mcountinhibit: begin
                mach_data = inhibit_word;
                mach_sel  = csr_pkg::sel_mcountinhibit;
            end
            csr_pkg::csr_addr_mscratch: begin
                mach_data = mscratch;
                mach_sel  = csr_pkg::sel_mscratch;
            end
            default: mach_hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // reply and write select
    ////////////////////////////////////////////////////////////////////////////
    assign mach_ok = !user_hit && mach_hit && (priv == csr_pkg::priv_machine);
    assign legal   = user_hit || mach_ok;

    always_comb begin
        if (user_hit) begin
            rd_data = user_data;
        end else if (mach_ok) begin
            rd_data = mach_data;
        end else begin
            rd_data = '0;                // unknown or not privileged
        end
    end

    assign illegal_csr = !legal && (req.rd_en || req.wr_en);

    // user counter addresses never reach here, they are read-only
    assign wr.sel  = (req.wr_en && mach_ok && !stall) ? mach_sel : csr_pkg::sel_none;
    assign wr.data = req.wr_data;

endmodule

//--- csr_counters.sv
module csr_counters (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_pkg::csr_wr_t       wr,
    input  logic                   stall,
    output csr_pkg::counter_vals_t counters
);

    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic        cy_inhibit;
    logic        ir_inhibit;
    logic [63:0] mcycle_next;
    logic [63:0] minstret_next;

    // increment, a half write replaces the whole result
    function automatic logic [63:0] count_next(
        input logic [63:0]    cur,
        input logic           inc,
        input logic           wr_lo,
        input logic           wr_hi,
        input csr_pkg::word_t data
    );
        logic [63:0] nxt;
        nxt = inc ? cur + 64'd1 : cur;
        if (wr_lo) begin
            nxt = {cur[63:32], data};
        end else if (wr_hi) begin
            nxt = {data, cur[31:0]};
        end
        return nxt;
    endfunction

    assign mcycle_next = count_next(mcycle, !cy_inhibit,
                                    wr.sel == csr_pkg::sel_mcycle_lo,
                                    wr.sel == csr_pkg::sel_mcycle_hi,
                                    wr.data);

    // instret only counts when the data bus is not holding the core
    assign minstret_next = count_next(minstret, !ir_inhibit && !stall,
                                      wr.sel == csr_pkg::sel_minstret_lo,
                                      wr.sel == csr_pkg::sel_minstret_hi,
                                      wr.data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle     <= '0;
            minstret   <= '0;
            cy_inhibit <= 1'b0;
            ir_inhibit <= 1'b0;
        end else begin
            mcycle   <= mcycle_next;
            minstret <= minstret_next;
            if (wr.sel == csr_pkg::sel_mcountinhibit) begin
                cy_inhibit <= wr.data[0];     // cy
                ir_inhibit <= wr.data[2];     // ir
            end
        end
    end

    assign counters.mcycle     = mcycle;
    assign counters.minstret   = minstret;
    assign counters.cy_inhibit = cy_inhibit;
    assign counters.ir_inhibit = ir_inhibit;

endmodule

//--- csr_machine_state.sv
module csr_machine_state (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_wr_t    wr,
    input  logic                stall,
    input  logic                trap,
    input  logic                mret,
    output csr_pkg::priv_mode_e priv,
    output csr_pkg::mstatus_t   status,
    output csr_pkg::word_t      mscratch,
    output logic                global_mie
);

    logic                mie;
    logic                mpie;
    csr_pkg::priv_mode_e mpp;

    ////////////////////////////////////////////////////////////////////////////
    // privilege mode and mstatus fields
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv     <= csr_pkg::priv_machine;
            mie      <= 1'b1;
            mpie     <= 1'b1;
            mpp      <= csr_pkg::priv_user;
            mscratch <= '0;
        end else begin
            // csr writes first, trap and mret below take priority
            case (wr.sel)
                csr_pkg::sel_mstatus: begin
                    mie  <= wr.data[3];
                    mpie <= wr.data[7];
                    // only u and m exist, anything else falls back to user
                    mpp  <= (wr.data[12:11] == csr_pkg::priv_machine)
                            ? csr_pkg::priv_machine
                            : csr_pkg::priv_user;
                end
                csr_pkg::sel_mscratch: mscratch <= wr.data;
                default: ;
            endcase

            if (trap && !stall) begin
                priv <= csr_pkg::priv_machine;
                mpie <= mie;
                mie  <= 1'b0;
                mpp  <= priv;                   // remember where we came from
            end else if (mret) begin
                priv <= mpp;
                mie  <= mpie;
                mpie <= 1'b1;
                mpp  <= csr_pkg::priv_user;     // least privileged mode
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // architected view
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        status      = '0;
        status.sie  = 1'b1;                     // hardwired set
        status.spie = 1'b1;
        status.mie  = mie;
        status.mpie = mpie;
        status.mpp  = mpp;
    end

    assign global_mie = mie;

endmodule

//--- csr_file.sv
module csr_file #(
    parameter csr_pkg::word_t hart_id = 32'h0,
    parameter csr_pkg::word_t impid   = 32'h1
) (
    input  logic                clk,
    input  logic                rst_n,

    // core access port
    input  csr_pkg::csr_req_t   req,
    output csr_pkg::word_t      rd_data,
    output logic                illegal_csr,

    // pipeline events
    input  logic                stall,          // data bus wait
    input  logic                trap,
    input  logic                mret,

    input  logic [63:0]         time_val,       // external timer

    output logic                global_mie,
    output csr_pkg::priv_mode_e priv
);

    csr_pkg::csr_wr_t       wr;
    csr_pkg::counter_vals_t counters;
    csr_pkg::mstatus_t      status;
    csr_pkg::word_t         mscratch;

    csr_decode #(
        .hart_id (hart_id),
        .impid   (impid)
    ) u_decode (
        .req         (req),
        .stall       (stall),
        .priv        (priv),
        .status      (status),
        .mscratch    (mscratch),
        .counters    (counters),
        .time_val    (time_val),
        .rd_data     (rd_data),
        .illegal_csr (illegal_csr),
        .wr          (wr)
    );

    csr_counters u_counters (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .stall    (stall),
        .counters (counters)
    );

    csr_machine_state u_machine_state (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .stall      (stall),
        .trap       (trap),
        .mret       (mret),
        .priv       (priv),
        .status     (status),
        .mscratch   (mscratch),
        .global_mie (global_mie)
    );

endmodule

//--- tb_csr_file.sv
module tb_csr_file;

    typedef enum logic [2:0] {
        op_idle,
        op_read,
        op_write,
        op_trap,
        op_mret
    } op_e;

    typedef enum logic [1:0] {
        chk_none,
        chk_eq,
        chk_above                             // rd_data must exceed data
    } chk_e;

    typedef struct packed {
        op_e                 op;
        csr_pkg::csr_addr_t  addr;
        csr_pkg::word_t      data;            // write value or expected read
        logic                stall;
        chk_e                chk;
        logic                exp_ill;
        csr_pkg::priv_mode_e exp_priv;
        logic                chk_mie;
        logic                exp_mie;
    } step_t;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    csr_pkg::csr_req_t   req;
    logic                stall;
    logic                trap;
    logic                mret;
    logic [63:0]         time_val;
    csr_pkg::word_t      rd_data;
    logic                illegal_csr;
    logic                global_mie;
    csr_pkg::priv_mode_e priv;

    step_t               steps[$];
    string               step_names[$];
    csr_pkg::priv_mode_e exp_mode = csr_pkg::priv_machine;
    logic [31:0]         lfsr_state = 32'hee379a36;
    int                  mismatch_errors = 0;
    int                  timeout_errors = 0;

    csr_pkg::word_t r_scratch, r_lost, r_misa, r_cyc_lo, r_cyc_hi;
    csr_pkg::word_t r_ir_lo, r_ir_hi, r_time_lo, r_time_hi;

    csr_file #(
        .hart_id (32'd5),
        .impid   (32'd1)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rd_data     (rd_data),
        .illegal_csr (illegal_csr),
        .stall       (stall),
        .trap        (trap),
        .mret        (mret),
        .time_val    (time_val),
        .global_mie  (global_mie),
        .priv        (priv)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random words
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic csr_pkg::word_t random_bits(input int n);
        csr_pkg::word_t w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};    // one step per bit
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compares
    ////////////////////////////////////////////////////////////////////////////
    task automatic verify_word(string name, csr_pkg::word_t exp, csr_pkg::word_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic above_check(string name, csr_pkg::word_t floor, csr_pkg::word_t act);
        if (!(act > floor)) begin
            mismatch_errors++;
            $display("FAIL %s: expected above %h, actual %h", name, floor, act);
        end
    endtask

    task automatic priv_check(string name, csr_pkg::priv_mode_e exp,
                              csr_pkg::priv_mode_e act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic flag_check(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // table building
    ////////////////////////////////////////////////////////////////////////////
    task automatic add_step(string name, op_e op, csr_pkg::csr_addr_t addr,
                            csr_pkg::word_t data, logic stall_bit, chk_e chk,
                            logic ill, logic mie_on, logic mie_val);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.stall    = stall_bit;
        s.chk      = chk;
        s.exp_ill  = ill;
        s.exp_priv = exp_mode;               // mode seen during this step
        s.chk_mie  = mie_on;
        s.exp_mie  = mie_val;
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    task automatic add_read(string name, csr_pkg::csr_addr_t addr, csr_pkg::word_t exp);
        add_step(name, op_read, addr, exp, 1'b0, chk_eq, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic add_write(string name, csr_pkg::csr_addr_t addr,
                             csr_pkg::word_t data, logic stall_bit);
        add_step(name, op_write, addr, data, stall_bit, chk_none, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic add_event(string name, op_e op);
        add_step(name, op, 12'h0, 32'h0, 1'b0, chk_none, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        add_event("after reset", op_idle);
        add_read("misa", csr_pkg::csr_addr_misa, 32'h4000_0100);
        add_read("mhartid", csr_pkg::csr_addr_mhartid, 32'd5);
        add_read("mimpid", csr_pkg::csr_addr_mimpid, 32'd1);
        add_read("mvendorid", csr_pkg::csr_addr_mvendorid, 32'h0);
        add_read("marchid", csr_pkg::csr_addr_marchid, 32'h0);
        add_read("mconfigptr", csr_pkg::csr_addr_mconfigptr, 32'h0);

        add_write("mscratch write", csr_pkg::csr_addr_mscratch, r_scratch, 1'b0);
        add_read("mscratch readback", csr_pkg::csr_addr_mscratch, r_scratch);
        add_write("misa write", csr_pkg::csr_addr_misa, r_misa, 1'b0);
        add_read("misa unchanged", csr_pkg::csr_addr_misa, 32'h4000_0100);
        add_write("stalled write", csr_pkg::csr_addr_mscratch, r_lost, 1'b1);
        add_read("stalled write lost", csr_pkg::csr_addr_mscratch, r_scratch);

        // mie 3, mpie 7, mpp 12:11, sie and spie hardwired
        add_write("mstatus ones", csr_pkg::csr_addr_mstatus, 32'hffff_ffff, 1'b0);
        add_step("mstatus ones read", op_read, csr_pkg::csr_addr_mstatus, 32'h0000_18aa,
                 1'b0, chk_eq, 1'b0, 1'b1, 1'b1);
        add_write("mstatus zero", csr_pkg::csr_addr_mstatus, 32'h0, 1'b0);
        add_step("mstatus zero read", op_read, csr_pkg::csr_addr_mstatus, 32'h0000_0022,
                 1'b0, chk_eq, 1'b0, 1'b1, 1'b0);

        add_write("inhibit both", csr_pkg::csr_addr_mcountinhibit, 32'h5, 1'b0);
        add_write("mcycle write", csr_pkg::csr_addr_mcycle, r_cyc_lo, 1'b0);
        add_write("mcycleh write", csr_pkg::csr_addr_mcycleh, r_cyc_hi, 1'b0);
        add_write("minstret write", csr_pkg::csr_addr_minstret, r_ir_lo, 1'b0);
        add_write("minstreth write", csr_pkg::csr_addr_minstreth, r_ir_hi, 1'b0);
        add_read("mcountinhibit", csr_pkg::csr_addr_mcountinhibit, 32'h5);
        add_read("mcycle", csr_pkg::csr_addr_mcycle, r_cyc_lo);
        add_read("mcycleh", csr_pkg::csr_addr_mcycleh, r_cyc_hi);
        add_read("cycle", csr_pkg::csr_addr_cycle, r_cyc_lo);
        add_read("cycleh", csr_pkg::csr_addr_cycleh, r_cyc_hi);
        add_read("minstret", csr_pkg::csr_addr_minstret, r_ir_lo);
        add_read("minstreth", csr_pkg::csr_addr_minstreth, r_ir_hi);
        add_read("instret", csr_pkg::csr_addr_instret, r_ir_lo);
        add_read("instreth", csr_pkg::csr_addr_instreth, r_ir_hi);
        add_write("inhibit clear", csr_pkg::csr_addr_mcountinhibit, 32'h0, 1'b0);
        add_event("counting", op_idle);
        add_step("mcycle advanced", op_read, csr_pkg::csr_addr_mcycle, r_cyc_lo,
                 1'b0, chk_above, 1'b0, 1'b0, 1'b0);

        add_read("time", csr_pkg::csr_addr_time, r_time_lo);
        add_read("timeh", csr_pkg::csr_addr_timeh, r_time_hi);

        // mpp user and mpie set, so the mret enables interrupts in user mode
        add_write("mstatus mpie only", csr_pkg::csr_addr_mstatus, 32'h0000_0080, 1'b0);
        add_event("mret", op_mret);
        exp_mode = csr_pkg::priv_user;
        add_step("mscratch from user", op_read, csr_pkg::csr_addr_mscratch, 32'h0,
                 1'b0, chk_none, 1'b1, 1'b1, 1'b1);
        add_step("cycle from user", op_read, csr_pkg::csr_addr_cycle, 32'h0,
                 1'b0, chk_none, 1'b0, 1'b0, 1'b0);
        add_event("trap", op_trap);
        exp_mode = csr_pkg::priv_machine;
        add_step("mstatus after trap", op_read, csr_pkg::csr_addr_mstatus, 32'h0000_00a2,
                 1'b0, chk_eq, 1'b0, 1'b1, 1'b0);
        add_event("final idle", op_idle);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // applying the table
    ////////////////////////////////////////////////////////////////////////////
    task automatic drive_step(step_t s);
        csr_pkg::csr_req_t r;
        r         = '0;
        r.rd_en   = (s.op == op_read);
        r.wr_en   = (s.op == op_write);
        r.addr    = s.addr;
        r.wr_data = (s.op == op_write) ? s.data : 32'h0;
        req   <= r;
        stall <= s.stall;
        trap  <= (s.op == op_trap);
        mret  <= (s.op == op_mret);
    endtask

    task automatic check_step(string name, step_t s);
        case (s.chk)
            chk_eq:    verify_word(name, s.data, rd_data);
            chk_above: above_check(name, s.data, rd_data);
            default:   ;
        endcase
        flag_check({name, " illegal_csr"}, s.exp_ill, illegal_csr);
        priv_check({name, " priv"}, s.exp_priv, priv);
        if (s.chk_mie) begin
            flag_check({name, " global_mie"}, s.exp_mie, global_mie);
        end
    endtask

    task automatic await_reset();
        int n;
        n = 0;
        while (!rst_n && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            timeout_errors++;
            $display("reset was still asserted after %0d cycles", n);
        end
    endtask

    task automatic run_steps();
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            drive_step(steps[i]);
            @(negedge clk);                  // outputs settled mid-cycle
            check_step(step_names[i], steps[i]);
        end
        @(posedge clk);
        req   <= '0;
        stall <= 1'b0;
        trap  <= 1'b0;
        mret  <= 1'b0;
    endtask

    initial begin
        r_scratch = random_bits(32);
        r_lost    = random_bits(32);
        r_misa    = random_bits(32);
        r_cyc_lo  = random_bits(31);         // headroom so mcycle cannot wrap
        r_cyc_hi  = random_bits(32);
        r_ir_lo   = random_bits(32);
        r_ir_hi   = random_bits(32);
        r_time_lo = random_bits(32);
        r_time_hi = random_bits(32);

        req      = '0;
        stall    = 1'b0;
        trap     = 1'b0;
        mret     = 1'b0;
        time_val = {r_time_hi, r_time_lo};

        build_table();
        await_reset();
        if (timeout_errors == 0) begin
            run_steps();
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
csr_pkg.sv
csr_decode.sv
csr_counters.sv
csr_machine_state.sv
csr_file.sv
tb_csr_file.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, then judge the log
rm -f sim.log && \
    verilator --binary --timing --top-module tb_csr_file -f all.f -o csr_sim && \
    ./obj_dir/csr_sim > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
